// File: all.f
+incdir+.
alu_ops_pkg.sv
core_types_pkg.sv
bit_scan.sv
scalar_alu.sv
scalar_reg_file.sv
instr_decode.sv
scalar_exec_top.sv
tb_scalar_exec.sv

// File: alu_ops_pkg.sv
/*
 * ALU operation package
 * Opcode encoding and the grouping of opcodes into result classes
 */
`default_nettype none

package alu_ops_pkg;

    typedef enum logic [5:0] {
        OP_OR     = 6'd0,
        OP_AND    = 6'd1,
        OP_UMINUS = 6'd2,
        OP_XOR    = 6'd3,
        OP_NOT    = 6'd4,
        OP_IADD   = 6'd5,
        OP_ISUB   = 6'd6,
        OP_ASR    = 6'd7,
        OP_LSR    = 6'd8,
        OP_LSL    = 6'd9,
        OP_CLZ    = 6'd10,
        OP_CTZ    = 6'd11,
        OP_COPY   = 6'd12,
        OP_EQUAL  = 6'd13,
        OP_NEQUAL = 6'd14,
        OP_SIGTR  = 6'd15,
        OP_SIGTE  = 6'd16,
        OP_SILT   = 6'd17,
        OP_SILTE  = 6'd18,
        OP_UIGTR  = 6'd19,
        OP_UIGTE  = 6'd20,
        OP_UILT   = 6'd21,
        OP_UILTE  = 6'd22
    } alu_op_e;

    typedef enum logic [1:0] {
        LOGIC   = 2'd0,
        ARITH   = 2'd1,
        SHIFT   = 2'd2,
        COMPARE = 2'd3
    } op_class_e;

    // Bit scans sit with the shifts; illegal codes fall into LOGIC
    function automatic op_class_e op_class(alu_op_e op);
        if (op >= OP_EQUAL && op <= OP_UILTE)
            return COMPARE;
        else if (op == OP_UMINUS || op == OP_IADD || op == OP_ISUB)
            return ARITH;
        else if (op >= OP_ASR && op <= OP_CTZ)
            return SHIFT;
        else
            return LOGIC;
    endfunction

endpackage

`default_nettype wire

// File: bit_scan.sv
/*
 * Bit scan
 * Leading and trailing zero counts of one data word
 */
`timescale 1ns/100ps
`default_nettype none
`include "core_settings.svh"

module bit_scan (
    input  wire [`DATA_WIDTH-1:0]   value_i,
    output logic [6:0]              leading_zeros_o,
    output logic [6:0]              trailing_zeros_o
);

    // Walk down from the MSB until the first set bit
    always_comb
    begin
        logic found;
        found = 1'b0;
        leading_zeros_o = '0;
        for (int i = `DATA_WIDTH - 1; i >= 0; i--)
        begin
            if (value_i[i])
                found = 1'b1;
            else if (!found)
                leading_zeros_o = leading_zeros_o + 7'd1;
        end
    end

    // Same walk from the LSB up
    always_comb
    begin
        logic found;
        found = 1'b0;
        trailing_zeros_o = '0;
        for (int i = 0; i < `DATA_WIDTH; i++)
        begin
            if (value_i[i])
                found = 1'b1;
            else if (!found)
                trailing_zeros_o = trailing_zeros_o + 7'd1;
        end
    end

endmodule

`default_nettype wire

// File: core_settings.svh
/*
 * Scalar execute slice settings
 * Data width, register count and instruction field widths
 */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Register and operand width
`define DATA_WIDTH      32
`define NUM_REGS        32
`define REG_IDX_WIDTH   5

// Immediate field, sign-extended to DATA_WIDTH
`define IMM_WIDTH       10

`endif

// File: core_types_pkg.sv
/*
 * Core types package
 * Instruction word, decoded operation and writeback record
 */
`default_nettype none
`include "core_settings.svh"

package core_types_pkg;

    // Field order from the top: op, dest, src1, src2, use_imm, imm
    typedef struct packed {
        alu_ops_pkg::alu_op_e       op;
        logic [`REG_IDX_WIDTH-1:0]  dest;
        logic [`REG_IDX_WIDTH-1:0]  src1;
        logic [`REG_IDX_WIDTH-1:0]  src2;
        logic                       use_imm;
        logic [`IMM_WIDTH-1:0]      imm;
    } instr_t;

    typedef struct packed {
        alu_ops_pkg::alu_op_e       op;
        logic [`REG_IDX_WIDTH-1:0]  dest;
        logic [`REG_IDX_WIDTH-1:0]  src1;
        logic [`REG_IDX_WIDTH-1:0]  src2;
        logic                       use_imm;
        logic [`DATA_WIDTH-1:0]     imm;
        logic                       legal;
    } decoded_t;

    typedef struct packed {
        logic                       valid;
        logic [`REG_IDX_WIDTH-1:0]  dest;
        logic [`DATA_WIDTH-1:0]     value;
    } writeback_t;

endpackage

`default_nettype wire

// File: instr_decode.sv
/*
 * Instruction decoder
 * Field split, opcode legality check and immediate sign extension
 */
`timescale 1ns/100ps
`default_nettype none
`include "core_settings.svh"

module instr_decode (
    input  wire core_types_pkg::instr_t     instr_i,
    output core_types_pkg::decoded_t        decoded_o
);

    localparam int EXT_W = `DATA_WIDTH - `IMM_WIDTH;

    logic                   imm_sign;
    logic [`DATA_WIDTH-1:0] imm_ext;
    logic                   op_defined;

    assign imm_sign = instr_i.imm[`IMM_WIDTH-1];
    assign imm_ext  = {{EXT_W{imm_sign}}, instr_i.imm};

    // Defined codes are packed from zero up to the last compare
    assign op_defined = instr_i.op <= alu_ops_pkg::OP_UILTE;

    always_comb
    begin
        decoded_o.op      = instr_i.op;
        decoded_o.dest    = instr_i.dest;
        decoded_o.src1    = instr_i.src1;
        decoded_o.src2    = instr_i.src2;
        decoded_o.use_imm = instr_i.use_imm;
        decoded_o.imm     = imm_ext;
        decoded_o.legal   = op_defined;
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Compile and run the scalar execute slice testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module tb_scalar_exec \
    -f all.f

./obj_dir/Vtb_scalar_exec > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST OK$" sim.log
then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// File: scalar_alu.sv
/*
 * Scalar ALU
 * Single-cycle logic, arithmetic, shift, bit scan and compare operations
 */
`timescale 1ns/100ps
`default_nettype none
`include "core_settings.svh"

module scalar_alu (
    input  wire alu_ops_pkg::alu_op_e   op_i,
    input  wire [`DATA_WIDTH-1:0]       operand1_i,
    input  wire [`DATA_WIDTH-1:0]       operand2_i,
    output logic [`DATA_WIDTH-1:0]      result_o
);

    localparam int SHAMT_W = $clog2(`DATA_WIDTH);

    logic [`DATA_WIDTH:0]   diff_ext;
    logic [`DATA_WIDTH-1:0] difference;
    logic                   borrow;
    logic                   negative;
    logic                   overflow;
    logic                   equal;
    logic                   signed_lt;
    logic [SHAMT_W-1:0]     shamt;
    logic [6:0]             lead_zeros;
    logic [6:0]             trail_zeros;
    logic [`DATA_WIDTH-1:0] logic_res;
    logic [`DATA_WIDTH-1:0] arith_res;
    logic [`DATA_WIDTH-1:0] shift_res;
    logic                   cmp_bit;

    bit_scan scan_i (
        .value_i          (operand2_i),
        .leading_zeros_o  (lead_zeros),
        .trailing_zeros_o (trail_zeros)
    );

    // One extra bit keeps the unsigned borrow
    assign diff_ext   = {1'b0, operand1_i} - {1'b0, operand2_i};
    assign difference = diff_ext[`DATA_WIDTH-1:0];
    assign borrow     = diff_ext[`DATA_WIDTH];
    assign negative   = difference[`DATA_WIDTH-1];
    assign overflow   = (operand1_i[`DATA_WIDTH-1] != operand2_i[`DATA_WIDTH-1])
                        && (difference[`DATA_WIDTH-1] != operand1_i[`DATA_WIDTH-1]);
    assign equal      = difference == '0;
    assign signed_lt  = negative ^ overflow;
    assign shamt      = operand2_i[SHAMT_W-1:0];

    always_comb
    begin
        case (op_i)
            alu_ops_pkg::OP_OR:   logic_res = operand1_i | operand2_i;
            alu_ops_pkg::OP_AND:  logic_res = operand1_i & operand2_i;
            alu_ops_pkg::OP_XOR:  logic_res = operand1_i ^ operand2_i;
            alu_ops_pkg::OP_NOT:  logic_res = ~operand2_i;
            alu_ops_pkg::OP_COPY: logic_res = operand2_i;
            default:              logic_res = '0;
        endcase
    end

    always_comb
    begin
        case (op_i)
            alu_ops_pkg::OP_UMINUS: arith_res = -operand2_i;
            alu_ops_pkg::OP_IADD:   arith_res = operand1_i + operand2_i;
            default:                arith_res = difference;
        endcase
    end

    always_comb
    begin
        case (op_i)
            alu_ops_pkg::OP_ASR: shift_res = $signed(operand1_i) >>> shamt;
            alu_ops_pkg::OP_LSR: shift_res = operand1_i >> shamt;
            // Large shift amounts clear the word
            alu_ops_pkg::OP_LSL: shift_res = |operand2_i[`DATA_WIDTH-1:SHAMT_W] ? '0
                                             : operand1_i << shamt;
            alu_ops_pkg::OP_CLZ: shift_res = {{(`DATA_WIDTH-7){1'b0}}, lead_zeros};
            default:             shift_res = {{(`DATA_WIDTH-7){1'b0}}, trail_zeros};
        endcase
    end

    always_comb
    begin
        case (op_i)
            alu_ops_pkg::OP_EQUAL:  cmp_bit = equal;
            alu_ops_pkg::OP_NEQUAL: cmp_bit = ~equal;
            alu_ops_pkg::OP_SIGTR:  cmp_bit = ~signed_lt & ~equal;
            alu_ops_pkg::OP_SIGTE:  cmp_bit = ~signed_lt;
            alu_ops_pkg::OP_SILT:   cmp_bit = signed_lt;
            alu_ops_pkg::OP_SILTE:  cmp_bit = signed_lt | equal;
            alu_ops_pkg::OP_UIGTR:  cmp_bit = ~borrow & ~equal;
            alu_ops_pkg::OP_UIGTE:  cmp_bit = ~borrow;
            alu_ops_pkg::OP_UILT:   cmp_bit = borrow;
            default:                cmp_bit = borrow | equal;
        endcase
    end

    always_comb
    begin
        case (alu_ops_pkg::op_class(op_i))
            alu_ops_pkg::ARITH:   result_o = arith_res;
            alu_ops_pkg::SHIFT:   result_o = shift_res;
            alu_ops_pkg::COMPARE: result_o = {{(`DATA_WIDTH-1){1'b0}}, cmp_bit};
            default:              result_o = logic_res;
        endcase
    end

endmodule

`default_nettype wire

// File: scalar_exec_top.sv
/*
 * Scalar execute slice
 * Decode, register read, ALU and registered writeback in one cycle
 */
`timescale 1ns/100ps
`default_nettype none
`include "core_settings.svh"

module scalar_exec_top (
    input  wire                         clk,
    input  wire                         reset_i,
    input  wire                         issue_i,
    input  wire core_types_pkg::instr_t instr_i,
    output core_types_pkg::writeback_t  wb_o,
    output logic                        illegal_o
);

    core_types_pkg::decoded_t   dec;
    logic [`DATA_WIDTH-1:0]     src1_data;
    logic [`DATA_WIDTH-1:0]     src2_data;
    logic [`DATA_WIDTH-1:0]     operand2;
    logic [`DATA_WIDTH-1:0]     alu_result;
    logic                       wr_en;
    logic                       wb_valid_q;
    logic                       illegal_q;
    logic [`REG_IDX_WIDTH-1:0]  wb_dest_q;
    logic [`DATA_WIDTH-1:0]     wb_value_q;

    instr_decode decode_i (
        .instr_i   (instr_i),
        .decoded_o (dec)
    );

    scalar_reg_file regs_i (
        .clk        (clk),
        .reset_i    (reset_i),
        .rd_idx1_i  (dec.src1),
        .rd_idx2_i  (dec.src2),
        .rd_data1_o (src1_data),
        .rd_data2_o (src2_data),
        .wr_en_i    (wr_en),
        .wr_idx_i   (dec.dest),
        .wr_data_i  (alu_result)
    );

    assign operand2 = dec.use_imm ? dec.imm : src2_data;

    scalar_alu alu_i (
        .op_i       (dec.op),
        .operand1_i (src1_data),
        .operand2_i (operand2),
        .result_o   (alu_result)
    );

    assign wr_en = issue_i & dec.legal;

    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            wb_valid_q <= 1'b0;
            illegal_q  <= 1'b0;
        end
        else
        begin
            wb_valid_q <= wr_en;
            illegal_q  <= issue_i & ~dec.legal;
        end
    end

    // Same edge as the register file write
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            wb_dest_q  <= dec.dest;
            wb_value_q <= alu_result;
        end
    end

    assign wb_o.valid = wb_valid_q;
    assign wb_o.dest  = wb_dest_q;
    assign wb_o.value = wb_value_q;
    assign illegal_o  = illegal_q;

endmodule

`default_nettype wire

// File: scalar_reg_file.sv
/*
 * Scalar register file
 * Two combinational read ports and one clocked write port
 */
`timescale 1ns/100ps
`default_nettype none
`include "core_settings.svh"

module scalar_reg_file (
    input  wire                         clk,
    input  wire                         reset_i,
    input  wire [`REG_IDX_WIDTH-1:0]    rd_idx1_i,
    input  wire [`REG_IDX_WIDTH-1:0]    rd_idx2_i,
    output logic [`DATA_WIDTH-1:0]      rd_data1_o,
    output logic [`DATA_WIDTH-1:0]      rd_data2_o,
    input  wire                         wr_en_i,
    input  wire [`REG_IDX_WIDTH-1:0]    wr_idx_i,
    input  wire [`DATA_WIDTH-1:0]       wr_data_i
);

    logic [`DATA_WIDTH-1:0] regs_q [`NUM_REGS];

    // All registers read as zero after reset
    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            for (int i = 0; i < `NUM_REGS; i++)
                regs_q[i] <= '0;
        end
        else if (wr_en_i)
        begin
            regs_q[wr_idx_i] <= wr_data_i;
        end
    end

    // Reads see the array as it stands, no bypass
    assign rd_data1_o = regs_q[rd_idx1_i];
    assign rd_data2_o = regs_q[rd_idx2_i];

endmodule

`default_nettype wire

// File: tb_scalar_exec.sv
/*
 * Scalar execute slice testbench
 * Register model and reference ALU, directed and random instructions
 */
`timescale 1ns/100ps
`default_nettype none
`include "core_settings.svh"

module tb_scalar_exec;

    localparam int TIMEOUT_CYCLES = 8;
    localparam logic [4:0] CMP_REGS [7] = '{5'd0, 5'd2, 5'd4, 5'd5, 5'd1, 5'd15, 5'd3};

    logic                       clk = 1'b0;
    logic                       reset_i;
    logic                       issue_i;
    core_types_pkg::instr_t     instr_i;
    core_types_pkg::writeback_t wb_o;
    logic                       illegal_o;

    logic                       wb_valid;
    logic [4:0]                 wb_dest;
    logic [`DATA_WIDTH-1:0]     wb_value;
    logic [5:0]                 issue_code;
    logic                       legal_issue;
    logic                       illegal_issue;

    logic [`DATA_WIDTH-1:0]     model_regs [`NUM_REGS];
    logic [4:0]                 next_dest;
    logic [`DATA_WIDTH-1:0]     next_value;
    logic [4:0]                 exp_dest_q;
    logic [`DATA_WIDTH-1:0]     exp_value_q;
    int                         errors = 0;
    int                         timeouts = 0;
    int                         issued = 0;
    integer                     seed;

    scalar_exec_top dut_i (
        .clk       (clk),
        .reset_i   (reset_i),
        .issue_i   (issue_i),
        .instr_i   (instr_i),
        .wb_o      (wb_o),
        .illegal_o (illegal_o)
    );

    always #10 clk = ~clk;

    assign wb_valid      = wb_o.valid;
    assign wb_dest       = wb_o.dest;
    assign wb_value      = wb_o.value;
    assign issue_code    = instr_i.op;
    // Codes 0 to 22 are defined
    assign legal_issue   = issue_i && (issue_code < 6'd23);
    assign illegal_issue = issue_i && (issue_code >= 6'd23);

    // Expected record follows the instruction sampled at this edge
    always @(posedge clk)
    begin
        exp_dest_q  <= next_dest;
        exp_value_q <= next_value;
    end

    assert property (@(posedge clk) disable iff (reset_i)
                     legal_issue |=> (wb_valid && !illegal_o))
    else
    begin
        errors = errors + 1;
        $display("No writeback or a raised illegal flag at %0t after a legal issue", $time);
    end

    assert property (@(posedge clk) disable iff (reset_i)
                     legal_issue |=> (wb_dest == exp_dest_q))
    else
    begin
        errors = errors + 1;
        $display("** Error at %0t: wb_o.dest expected %0d, actual %0d",
                 $time, $sampled(exp_dest_q), $sampled(wb_dest));
    end

    assert property (@(posedge clk) disable iff (reset_i)
                     legal_issue |=> (wb_value == exp_value_q))
    else
    begin
        errors = errors + 1;
        $display("** Error at %0t: wb_o.value expected %h, actual %h",
                 $time, $sampled(exp_value_q), $sampled(wb_value));
    end

    assert property (@(posedge clk) disable iff (reset_i)
                     illegal_issue |=> (illegal_o && !wb_valid))
    else
    begin
        errors = errors + 1;
        $display("Illegal opcode at %0t not flagged, or it wrote back", $time);
    end

    assert property (@(posedge clk) disable iff (reset_i)
                     !issue_i |=> (!illegal_o && !wb_valid))
    else
    begin
        errors = errors + 1;
        $display("Output active at %0t without an issue", $time);
    end

    // Reference ALU with b as operand 2
    function automatic logic [`DATA_WIDTH-1:0] expected_result(logic [5:0] op,
                                                               logic [`DATA_WIDTH-1:0] a,
                                                               logic [`DATA_WIDTH-1:0] b);
        logic [`DATA_WIDTH-1:0] r;
        int                     n;
        r = '0;
        n = 0;
        case (op)
            alu_ops_pkg::OP_OR:     r = a | b;
            alu_ops_pkg::OP_AND:    r = a & b;
            alu_ops_pkg::OP_UMINUS: r = 32'd0 - b;
            alu_ops_pkg::OP_XOR:    r = a ^ b;
            alu_ops_pkg::OP_NOT:    r = ~b;
            alu_ops_pkg::OP_IADD:   r = a + b;
            alu_ops_pkg::OP_ISUB:   r = a - b;
            alu_ops_pkg::OP_ASR:    r = $signed(a) >>> b[4:0];
            alu_ops_pkg::OP_LSR:    r = a >> b[4:0];
            alu_ops_pkg::OP_LSL:    r = (b[31:5] != 27'd0) ? 32'd0 : (a << b[4:0]);
            alu_ops_pkg::OP_CLZ:
            begin
                while (n < 32 && !b[31 - n])
                    n++;
                r = 32'(n);
            end
            alu_ops_pkg::OP_CTZ:
            begin
                while (n < 32 && !b[n])
                    n++;
                r = 32'(n);
            end
            alu_ops_pkg::OP_COPY:   r = b;
            alu_ops_pkg::OP_EQUAL:  r = 32'(a == b);
            alu_ops_pkg::OP_NEQUAL: r = 32'(a != b);
            alu_ops_pkg::OP_SIGTR:  r = 32'($signed(a) > $signed(b));
            alu_ops_pkg::OP_SIGTE:  r = 32'($signed(a) >= $signed(b));
            alu_ops_pkg::OP_SILT:   r = 32'($signed(a) < $signed(b));
            alu_ops_pkg::OP_SILTE:  r = 32'($signed(a) <= $signed(b));
            alu_ops_pkg::OP_UIGTR:  r = 32'(a > b);
            alu_ops_pkg::OP_UIGTE:  r = 32'(a >= b);
            alu_ops_pkg::OP_UILT:   r = 32'(a < b);
            alu_ops_pkg::OP_UILTE:  r = 32'(a <= b);
            default:                r = '0;
        endcase
        return r;
    endfunction

    // Drives one instruction and updates the register model
    task automatic issue_op(input logic [5:0] op, input logic [4:0] dest,
                            input logic [4:0] src1, input logic [4:0] src2,
                            input logic use_imm, input logic [9:0] imm);
        logic [`DATA_WIDTH-1:0] b;
        logic [`DATA_WIDTH-1:0] res;
        @(negedge clk);
        instr_i = core_types_pkg::instr_t'({op, dest, src1, src2, use_imm, imm});
        issue_i = 1'b1;
        issued++;
        b = use_imm ? {{22{imm[9]}}, imm} : model_regs[src2];
        if (op < 6'd23)
        begin
            res = expected_result(op, model_regs[src1], b);
            model_regs[dest] = res;
            next_dest = dest;
            next_value = res;
        end
    endtask

    task automatic wait_result();
        int cycles;
        cycles = 0;
        @(negedge clk);
        issue_i = 1'b0;
        while (!(wb_valid || illegal_o) && cycles < TIMEOUT_CYCLES)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!(wb_valid || illegal_o))
        begin
            timeouts++;
            $display("Timeout at %0t: no writeback and no illegal flag after issue", $time);
        end
    endtask

    task automatic run_op(input logic [5:0] op, input logic [4:0] dest,
                          input logic [4:0] src1, input logic [4:0] src2,
                          input logic use_imm, input logic [9:0] imm);
        issue_op(op, dest, src1, src2, use_imm, imm);
        wait_result();
    endtask

    initial
    begin
        logic [31:0] rnd;
        logic [31:0] fields;
        logic [5:0]  op;
        seed = 67648;
        reset_i = 1'b1;
        issue_i = 1'b0;
        instr_i = '0;
        next_dest = '0;
        next_value = '0;
        for (int r = 0; r < `NUM_REGS; r++)
            model_regs[r] = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        // Every register reads zero after reset
        for (int r = 0; r < `NUM_REGS; r++)
            run_op(alu_ops_pkg::OP_COPY, 5'(r), 5'd0, 5'(r), 1'b0, 10'd0);

        run_op(alu_ops_pkg::OP_COPY, 5'd1, 5'd0, 5'd0, 1'b1, 10'h3FF);
        run_op(alu_ops_pkg::OP_COPY, 5'd2, 5'd0, 5'd0, 1'b1, 10'd511);
        run_op(alu_ops_pkg::OP_COPY, 5'd3, 5'd0, 5'd0, 1'b1, 10'h200);
        run_op(alu_ops_pkg::OP_LSR, 5'd4, 5'd1, 5'd0, 1'b1, 10'd1);
        run_op(alu_ops_pkg::OP_IADD, 5'd5, 5'd4, 5'd0, 1'b1, 10'd1);
        run_op(alu_ops_pkg::OP_IADD, 5'd6, 5'd2, 5'd3, 1'b0, 10'd0);
        run_op(alu_ops_pkg::OP_ISUB, 5'd7, 5'd3, 5'd2, 1'b0, 10'd0);
        run_op(alu_ops_pkg::OP_ISUB, 5'd8, 5'd5, 5'd0, 1'b1, 10'd1);
        run_op(alu_ops_pkg::OP_UMINUS, 5'd9, 5'd0, 5'd5, 1'b0, 10'd0);
        run_op(alu_ops_pkg::OP_UMINUS, 5'd10, 5'd0, 5'd0, 1'b1, 10'd7);
        run_op(alu_ops_pkg::OP_AND, 5'd11, 5'd1, 5'd2, 1'b0, 10'd0);
        run_op(alu_ops_pkg::OP_OR, 5'd12, 5'd3, 5'd0, 1'b1, 10'h0F5);
        run_op(alu_ops_pkg::OP_XOR, 5'd13, 5'd4, 5'd1, 1'b0, 10'd0);
        run_op(alu_ops_pkg::OP_NOT, 5'd14, 5'd0, 5'd2, 1'b0, 10'd0);
        run_op(alu_ops_pkg::OP_COPY, 5'd15, 5'd0, 5'd0, 1'b1, 10'd5);

        // Shift amounts 0, 1 and 31 on a negative and the top bit
        for (int s = 7; s <= 9; s++)
        begin
            run_op(6'(s), 5'd20, 5'd3, 5'd0, 1'b1, 10'd0);
            run_op(6'(s), 5'd20, 5'd3, 5'd0, 1'b1, 10'd1);
            run_op(6'(s), 5'd20, 5'd5, 5'd0, 1'b1, 10'd31);
            run_op(6'(s), 5'd20, 5'd1, 5'd0, 1'b1, 10'd31);
        end
        run_op(alu_ops_pkg::OP_LSL, 5'd20, 5'd4, 5'd0, 1'b1, 10'd32);
        run_op(alu_ops_pkg::OP_LSL, 5'd20, 5'd4, 5'd0, 1'b1, 10'h3FF);
        run_op(alu_ops_pkg::OP_LSL, 5'd20, 5'd4, 5'd5, 1'b0, 10'd0);
        run_op(alu_ops_pkg::OP_CLZ, 5'd20, 5'd0, 5'd0, 1'b1, 10'd0);
        run_op(alu_ops_pkg::OP_CTZ, 5'd20, 5'd0, 5'd0, 1'b1, 10'd0);
        run_op(alu_ops_pkg::OP_COPY, 5'd16, 5'd0, 5'd0, 1'b1, 10'd1);
        for (int k = 0; k < 32; k++)
        begin
            run_op(alu_ops_pkg::OP_LSL, 5'd17, 5'd16, 5'd0, 1'b1, 10'(k));
            run_op(alu_ops_pkg::OP_CLZ, 5'd18, 5'd0, 5'd17, 1'b0, 10'd0);
            run_op(alu_ops_pkg::OP_CTZ, 5'd19, 5'd0, 5'd17, 1'b0, 10'd0);
        end

        // Pairs cover equality, sign bit and signed overflow
        for (int i = 0; i < 7; i++)
            for (int j = 0; j < 7; j++)
                for (int c = 13; c <= 22; c++)
                    run_op(6'(c), 5'd20, CMP_REGS[i], CMP_REGS[j], 1'b0, 10'd0);

        for (int c = 23; c < 64; c++)
        begin
            run_op(6'(c), 5'd4, 5'd1, 5'd2, 1'b0, 10'd0);
            run_op(alu_ops_pkg::OP_COPY, 5'd21, 5'd0, 5'd4, 1'b0, 10'd0);
        end

        // Back to back over a small register window for frequent dependencies
        for (int n = 0; n < 400; n++)
        begin
            rnd = $random(seed);
            fields = $random(seed);
            op = (rnd[1:0] == 2'd0) ? rnd[13:8] : 6'(rnd % 32'd23);
            issue_op(op, {2'b00, fields[2:0]}, {2'b00, fields[5:3]},
                     {2'b00, fields[8:6]}, fields[9], fields[25:16]);
        end
        wait_result();
        repeat (3) @(negedge clk);

        $display("Issued %0d instructions, %0d errors, %0d timeouts", issued, errors, timeouts);
        if (errors == 0 && timeouts == 0)
        begin
            $display("TEST OK");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
